/* design/ldq_pkg.sv */
`default_nettype none

package ldq_pkg;

    localparam int PREG_W    = 6;
    localparam int ROB_W     = 6;  // top bit is the wrap direction.
    localparam int LQ_W      = 5;
    localparam int IMM_W     = 12;
    localparam int PAYLOAD_W = IMM_W + PREG_W + ROB_W + LQ_W;

    // one dispatch port per bank, fixed by lq parity steering.
    localparam int DIS_PORTS = 2;

    // payload fields run imm, rd, rob, lq from the top.
    localparam int PL_ROB_LSB = LQ_W;

    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [ROB_W-1:0]     rob_idx_t;
    typedef logic [LQ_W-1:0]      lq_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;
    typedef logic [PAYLOAD_W-1:0] payload_t;

    // true when entry sits before the redirect point in program order.
    function automatic logic is_older(input rob_idx_t entry, input rob_idx_t redir);
        return (entry[ROB_W-1] ^ redir[ROB_W-1]) ^ (redir[ROB_W-2:0] > entry[ROB_W-2:0]);
    endfunction

endpackage

`default_nettype wire

/* design/payload_ram.sv */
`default_nettype none

module payload_ram #(
    parameter int DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  ldq_pkg::payload_t        wdata_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output ldq_pkg::payload_t        rdata_o
);
    import ldq_pkg::*;

    payload_t mem_q [DEPTH];

    // one write port from dispatch, one read port toward issue.
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
        rdata_o <= mem_q[raddr_i];  // registered read.
    end

endmodule

`default_nettype wire

/* design/dispatch_router.sv */
`default_nettype none

module dispatch_router (
    input  logic              [ldq_pkg::DIS_PORTS-1:0] dis_valid_i,
    input  ldq_pkg::preg_t    [ldq_pkg::DIS_PORTS-1:0] dis_rs1_i,
    input  logic              [ldq_pkg::DIS_PORTS-1:0] dis_rs1_ready_i,
    input  ldq_pkg::preg_t    [ldq_pkg::DIS_PORTS-1:0] dis_rd_i,
    input  ldq_pkg::imm_t     [ldq_pkg::DIS_PORTS-1:0] dis_imm_i,
    input  ldq_pkg::rob_idx_t [ldq_pkg::DIS_PORTS-1:0] dis_rob_idx_i,
    input  ldq_pkg::lq_idx_t  [ldq_pkg::DIS_PORTS-1:0] dis_lq_idx_i,
    input  logic              [ldq_pkg::DIS_PORTS-1:0] bank_full_i,
    output logic                                       dis_stall_o,
    output logic              [ldq_pkg::DIS_PORTS-1:0] bank_we_o,
    output ldq_pkg::preg_t    [ldq_pkg::DIS_PORTS-1:0] bank_rs1_o,
    output logic              [ldq_pkg::DIS_PORTS-1:0] bank_rs1_ready_o,
    output ldq_pkg::payload_t [ldq_pkg::DIS_PORTS-1:0] bank_payload_o
);
    import ldq_pkg::*;

    logic stall;

    // any full bank holds the whole dispatch group.
    assign stall       = (|bank_full_i) & (|dis_valid_i);
    assign dis_stall_o = stall;

    always_comb begin
        for (int b = 0; b < DIS_PORTS; b++) begin
            bank_we_o[b]        = 1'b0;
            bank_rs1_o[b]       = '0;
            bank_rs1_ready_o[b] = 1'b0;
            bank_payload_o[b]   = '0;
            // ports of one group carry consecutive lq indexes, so one match per bank.
            for (int p = 0; p < DIS_PORTS; p++) begin
                if (dis_valid_i[p] && (dis_lq_idx_i[p][0] == 1'(b))) begin
                    bank_we_o[b]        = ~stall;
                    bank_rs1_o[b]       = dis_rs1_i[p];
                    bank_rs1_ready_o[b] = dis_rs1_ready_i[p];
                    bank_payload_o[b]   = {dis_imm_i[p], dis_rd_i[p],
                                           dis_rob_idx_i[p], dis_lq_idx_i[p]};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/load_issue_bank.sv */
`default_nettype none

module load_issue_bank #(
    parameter int BANK_SIZE    = 8,
    parameter int WAKEUP_PORTS = 2
) (
    input  logic                                        clk,
    input  logic                                        rst,

    input  logic                                        we_i,
    input  ldq_pkg::preg_t                              rs1_i,
    input  logic                                        rs1_ready_i,
    input  ldq_pkg::payload_t                           payload_i,

    input  logic              [WAKEUP_PORTS-1:0]        wakeup_valid_i,
    input  ldq_pkg::preg_t    [WAKEUP_PORTS-1:0]        wakeup_preg_i,

    input  logic                                        success_i,
    input  logic              [$clog2(BANK_SIZE)-1:0]   success_slot_i,
    input  logic                                        replay_i,
    input  logic              [$clog2(BANK_SIZE)-1:0]   replay_slot_i,

    input  logic                                        redirect_i,
    input  ldq_pkg::rob_idx_t                           redirect_rob_i,

    output logic                                        full_o,
    output logic              [$clog2(BANK_SIZE):0]     occupancy_o,
    output logic                                        sel_valid_o,
    output logic              [$clog2(BANK_SIZE)-1:0]   sel_slot_o,
    output ldq_pkg::rob_idx_t                           sel_rob_o,
    output ldq_pkg::payload_t                           rd_payload_o
);
    import ldq_pkg::*;

    localparam int SLOT_W = $clog2(BANK_SIZE);
    localparam int OCC_W  = SLOT_W + 1;

    logic     [BANK_SIZE-1:0] valid_q;
    logic     [BANK_SIZE-1:0] issued_q;
    logic     [BANK_SIZE-1:0] rdy_q;
    preg_t                    rs1_q [BANK_SIZE];
    rob_idx_t                 rob_q [BANK_SIZE];

    logic     [BANK_SIZE-1:0] cand;
    logic     [BANK_SIZE-1:0] wake_hit;
    logic     [BANK_SIZE-1:0] alloc_oh;
    logic     [BANK_SIZE-1:0] sel_oh;
    logic     [BANK_SIZE-1:0] replay_oh;
    logic     [BANK_SIZE-1:0] done;
    logic     [BANK_SIZE-1:0] kill;
    logic     [BANK_SIZE-1:0] gone;
    logic     [SLOT_W-1:0]    free_slot;
    logic     [SLOT_W-1:0]    sel_slot;
    logic     [SLOT_W-1:0]    rd_addr_q;
    logic     [OCC_W-1:0]     occ_q;
    logic     [OCC_W-1:0]     gone_cnt;
    logic                     alloc;
    logic                     sel_fire;
    logic                     new_hit;

    // ******************************************************************
    // allocate and select, lowest slot first
    // ******************************************************************
    assign alloc = we_i & ~redirect_i;  // group is younger than any redirect.
    assign cand  = valid_q & rdy_q & ~issued_q;

    always_comb begin
        free_slot = '0;
        sel_slot  = '0;
        for (int i = BANK_SIZE - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_slot = SLOT_W'(i);
            end
            if (cand[i]) begin
                sel_slot = SLOT_W'(i);
            end
        end
    end

    assign sel_fire = (|cand) & ~redirect_i;

    // wakeup also matches the entry being written.
    always_comb begin
        wake_hit = '0;
        new_hit  = 1'b0;
        for (int w = 0; w < WAKEUP_PORTS; w++) begin
            for (int i = 0; i < BANK_SIZE; i++) begin
                if (wakeup_valid_i[w] && (wakeup_preg_i[w] == rs1_q[i])) begin
                    wake_hit[i] = 1'b1;
                end
            end
            if (wakeup_valid_i[w] && (wakeup_preg_i[w] == rs1_i)) begin
                new_hit = 1'b1;
            end
        end
    end

    always_comb begin
        gone_cnt = '0;
        for (int i = 0; i < BANK_SIZE; i++) begin
            alloc_oh[i]  = alloc && (free_slot == SLOT_W'(i));
            sel_oh[i]    = sel_fire && (sel_slot == SLOT_W'(i));
            replay_oh[i] = replay_i && (replay_slot_i == SLOT_W'(i));
            done[i]      = success_i && (success_slot_i == SLOT_W'(i)) && valid_q[i];
            kill[i]      = redirect_i && valid_q[i] && !is_older(rob_q[i], redirect_rob_i);
            gone[i]      = done[i] | kill[i];
            gone_cnt     = gone_cnt + OCC_W'(gone[i]);
        end
    end

    // ******************************************************************
    // entry state
    // ******************************************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q  <= '0;
            issued_q <= '0;
            rdy_q    <= '0;
            occ_q    <= '0;
        end else begin
            valid_q  <= (valid_q & ~gone) | alloc_oh;
            issued_q <= (issued_q | sel_oh) & ~replay_oh & ~alloc_oh;  // replay reopens select.
            rdy_q    <= ((rdy_q | wake_hit) & ~alloc_oh) |
                        (alloc_oh & {BANK_SIZE{rs1_ready_i | new_hit}});
            occ_q    <= occ_q + OCC_W'(alloc) - gone_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rs1_q[free_slot] <= rs1_i;
            rob_q[free_slot] <= payload_i[PL_ROB_LSB +: $bits(rob_idx_t)];
        end
        rd_addr_q <= sel_slot;  // read address taken at the select edge.
    end

    payload_ram #(
        .DEPTH (BANK_SIZE)
    ) i_payload_ram (
        .clk     (clk),
        .we_i    (alloc),
        .waddr_i (free_slot),
        .wdata_i (payload_i),
        .raddr_i (rd_addr_q),
        .rdata_o (rd_payload_o)
    );

    assign full_o      = &valid_q;
    assign occupancy_o = occ_q;
    assign sel_valid_o = sel_fire;
    assign sel_slot_o  = sel_slot;
    assign sel_rob_o   = rob_q[sel_slot];

endmodule

`default_nettype wire

/* design/issue_stage.sv */
`default_nettype none

module issue_stage #(
    parameter int BANK_SIZE = 8
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               sel_valid_i,
    input  logic [$clog2(BANK_SIZE)-1:0]       sel_slot_i,
    input  ldq_pkg::rob_idx_t                  sel_rob_i,
    input  ldq_pkg::payload_t                  payload_i,
    input  logic                               redirect_i,
    input  ldq_pkg::rob_idx_t                  redirect_rob_i,
    output logic                               issue_valid_o,
    output logic [$clog2(BANK_SIZE)-1:0]       issue_slot_o,
    output ldq_pkg::payload_t                  issue_payload_o
);
    import ldq_pkg::*;

    localparam int SLOT_W = $clog2(BANK_SIZE);

    logic              v1_q;
    logic              v2_q;
    logic [SLOT_W-1:0] slot1_q;
    logic [SLOT_W-1:0] slot2_q;
    rob_idx_t          rob1_q;
    logic              kill0;
    logic              kill1;

    // younger issues die at either stage.
    assign kill0 = redirect_i & ~is_older(sel_rob_i, redirect_rob_i);
    assign kill1 = redirect_i & ~is_older(rob1_q, redirect_rob_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else begin
            v1_q <= sel_valid_i & ~kill0;
            v2_q <= v1_q & ~kill1;
        end
    end

    always_ff @(posedge clk) begin
        slot1_q <= sel_slot_i;
        rob1_q  <= sel_rob_i;
        slot2_q <= slot1_q;
    end

    assign issue_valid_o   = v2_q;
    assign issue_slot_o    = slot2_q;
    assign issue_payload_o = payload_i;  // ram data lands with stage two.

endmodule

`default_nettype wire

/* design/load_issue_top.sv */
`default_nettype none

module load_issue_top #(
    parameter int BANK_SIZE    = 8,
    parameter int WAKEUP_PORTS = 2
) (
    input  logic                                                   clk,
    input  logic                                                   rst,

    input  logic                    [ldq_pkg::DIS_PORTS-1:0]       dis_valid_i,
    input  ldq_pkg::preg_t          [ldq_pkg::DIS_PORTS-1:0]       dis_rs1_i,
    input  logic                    [ldq_pkg::DIS_PORTS-1:0]       dis_rs1_ready_i,
    input  ldq_pkg::preg_t          [ldq_pkg::DIS_PORTS-1:0]       dis_rd_i,
    input  ldq_pkg::imm_t           [ldq_pkg::DIS_PORTS-1:0]       dis_imm_i,
    input  ldq_pkg::rob_idx_t       [ldq_pkg::DIS_PORTS-1:0]       dis_rob_idx_i,
    input  ldq_pkg::lq_idx_t        [ldq_pkg::DIS_PORTS-1:0]       dis_lq_idx_i,
    output logic                                                   dis_stall_o,

    input  logic                    [WAKEUP_PORTS-1:0]             wakeup_valid_i,
    input  ldq_pkg::preg_t          [WAKEUP_PORTS-1:0]             wakeup_preg_i,

    input  logic                    [ldq_pkg::DIS_PORTS-1:0]       success_i,
    input  logic [ldq_pkg::DIS_PORTS-1:0][$clog2(BANK_SIZE)-1:0]   success_slot_i,
    input  logic                    [ldq_pkg::DIS_PORTS-1:0]       replay_i,
    input  logic [ldq_pkg::DIS_PORTS-1:0][$clog2(BANK_SIZE)-1:0]   replay_slot_i,

    input  logic                                                   redirect_i,
    input  ldq_pkg::rob_idx_t                                      redirect_rob_i,

    output logic                    [ldq_pkg::DIS_PORTS-1:0]       issue_valid_o,
    output logic [ldq_pkg::DIS_PORTS-1:0][$clog2(BANK_SIZE)-1:0]   issue_slot_o,
    output ldq_pkg::payload_t       [ldq_pkg::DIS_PORTS-1:0]       issue_payload_o,
    output logic [ldq_pkg::DIS_PORTS-1:0][$clog2(BANK_SIZE):0]     occupancy_o
);
    import ldq_pkg::*;

    localparam int SLOT_W = $clog2(BANK_SIZE);

    logic     [DIS_PORTS-1:0]             bank_full;
    logic     [DIS_PORTS-1:0]             bank_we;
    preg_t    [DIS_PORTS-1:0]             bank_rs1;
    logic     [DIS_PORTS-1:0]             bank_rs1_ready;
    payload_t [DIS_PORTS-1:0]             bank_payload;
    logic     [DIS_PORTS-1:0]             sel_valid;
    logic     [DIS_PORTS-1:0][SLOT_W-1:0] sel_slot;
    rob_idx_t [DIS_PORTS-1:0]             sel_rob;
    payload_t [DIS_PORTS-1:0]             rd_payload;

    dispatch_router i_dispatch_router (
        .dis_valid_i      (dis_valid_i),
        .dis_rs1_i        (dis_rs1_i),
        .dis_rs1_ready_i  (dis_rs1_ready_i),
        .dis_rd_i         (dis_rd_i),
        .dis_imm_i        (dis_imm_i),
        .dis_rob_idx_i    (dis_rob_idx_i),
        .dis_lq_idx_i     (dis_lq_idx_i),
        .bank_full_i      (bank_full),
        .dis_stall_o      (dis_stall_o),
        .bank_we_o        (bank_we),
        .bank_rs1_o       (bank_rs1),
        .bank_rs1_ready_o (bank_rs1_ready),
        .bank_payload_o   (bank_payload)
    );

    // ******************************************************************
    // per-bank select and issue
    // ******************************************************************
    for (genvar b = 0; b < DIS_PORTS; b++) begin : g_bank
        load_issue_bank #(
            .BANK_SIZE    (BANK_SIZE),
            .WAKEUP_PORTS (WAKEUP_PORTS)
        ) i_load_issue_bank (
            .clk            (clk),
            .rst            (rst),
            .we_i           (bank_we[b]),
            .rs1_i          (bank_rs1[b]),
            .rs1_ready_i    (bank_rs1_ready[b]),
            .payload_i      (bank_payload[b]),
            .wakeup_valid_i (wakeup_valid_i),
            .wakeup_preg_i  (wakeup_preg_i),
            .success_i      (success_i[b]),
            .success_slot_i (success_slot_i[b]),
            .replay_i       (replay_i[b]),
            .replay_slot_i  (replay_slot_i[b]),
            .redirect_i     (redirect_i),
            .redirect_rob_i (redirect_rob_i),
            .full_o         (bank_full[b]),
            .occupancy_o    (occupancy_o[b]),
            .sel_valid_o    (sel_valid[b]),
            .sel_slot_o     (sel_slot[b]),
            .sel_rob_o      (sel_rob[b]),
            .rd_payload_o   (rd_payload[b])
        );

        issue_stage #(
            .BANK_SIZE (BANK_SIZE)
        ) i_issue_stage (
            .clk             (clk),
            .rst             (rst),
            .sel_valid_i     (sel_valid[b]),
            .sel_slot_i      (sel_slot[b]),
            .sel_rob_i       (sel_rob[b]),
            .payload_i       (rd_payload[b]),
            .redirect_i      (redirect_i),
            .redirect_rob_i  (redirect_rob_i),
            .issue_valid_o   (issue_valid_o[b]),
            .issue_slot_o    (issue_slot_o[b]),
            .issue_payload_o (issue_payload_o[b])
        );
    end

endmodule

`default_nettype wire

/* dv/load_issue_tb.sv */
`default_nettype none

module load_issue_tb;
    import ldq_pkg::*;

    localparam int BANK_SIZE = 8;
    localparam int SLOT_W    = $clog2(BANK_SIZE);
    localparam int EXP_W     = SLOT_W + PAYLOAD_W;  // {slot, payload}.

    typedef struct {
        logic [1:0]             dv;
        logic [1:0]             rdy;
        preg_t [1:0]            rs1;
        imm_t [1:0]             imm;
        rob_idx_t               rob;        // port 1 takes rob + 1.
        lq_idx_t                lq;         // port 1 takes lq + 1.
        logic [1:0]             wk;         // one bit per wakeup port.
        preg_t                  wk_preg;
        logic [1:0]             suc;
        logic [1:0]             rep;
        logic [1:0][SLOT_W-1:0] slot;       // success or replay slot per bank.
        logic                   redir;
        rob_idx_t               redir_rob;
        logic                   exp_stall;
        int                     occ0;       // -1 skips the check.
        int                     occ1;
    } step_t;

    logic                         clk;
    logic                         rst;
    logic [1:0]                   dis_valid;
    preg_t [1:0]                  dis_rs1;
    logic [1:0]                   dis_rs1_ready;
    preg_t [1:0]                  dis_rd;
    imm_t [1:0]                   dis_imm;
    rob_idx_t [1:0]               dis_rob;
    lq_idx_t [1:0]                dis_lq;
    logic                         dis_stall;
    logic [1:0]                   wk_valid;
    preg_t [1:0]                  wk_preg;
    logic [1:0]                   success;
    logic [1:0][SLOT_W-1:0]       success_slot;
    logic [1:0]                   replay;
    logic [1:0][SLOT_W-1:0]       replay_slot;
    logic                         redirect;
    rob_idx_t                     redirect_rob;
    logic [1:0]                   issue_valid;
    logic [1:0][SLOT_W-1:0]       issue_slot;
    payload_t [1:0]               issue_payload;
    logic [1:0][SLOT_W:0]         occupancy;

    step_t            steps [$];
    logic [EXP_W-1:0] exp_q [2][$];
    logic             m_valid [2][BANK_SIZE];   // scoreboard copy of each bank.
    logic             m_rdy [2][BANK_SIZE];
    preg_t            m_rs1 [2][BANK_SIZE];
    payload_t         m_pl [2][BANK_SIZE];
    int               errors;
    int               checks;
    int               cycles;
    int               limit;

    load_issue_top #(
        .BANK_SIZE    (BANK_SIZE),
        .WAKEUP_PORTS (2)
    ) i_load_issue_top (
        .clk             (clk),
        .rst             (rst),
        .dis_valid_i     (dis_valid),
        .dis_rs1_i       (dis_rs1),
        .dis_rs1_ready_i (dis_rs1_ready),
        .dis_rd_i        (dis_rd),
        .dis_imm_i       (dis_imm),
        .dis_rob_idx_i   (dis_rob),
        .dis_lq_idx_i    (dis_lq),
        .dis_stall_o     (dis_stall),
        .wakeup_valid_i  (wk_valid),
        .wakeup_preg_i   (wk_preg),
        .success_i       (success),
        .success_slot_i  (success_slot),
        .replay_i        (replay),
        .replay_slot_i   (replay_slot),
        .redirect_i      (redirect),
        .redirect_rob_i  (redirect_rob),
        .issue_valid_o   (issue_valid),
        .issue_slot_o    (issue_slot),
        .issue_payload_o (issue_payload),
        .occupancy_o     (occupancy)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (!rst) begin
            cycles <= cycles + 1;
            if (limit > 0 && cycles >= limit) begin
                $display("timeout: no end of the test table after %0d cycles", limit);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
    end

    // ********************************************************************
    // scoreboard model
    // ********************************************************************
    function automatic logic older_than(input rob_idx_t e, input rob_idx_t r);
        if (e[ROB_W-1] == r[ROB_W-1]) begin
            return e[ROB_W-2:0] < r[ROB_W-2:0];
        end
        return e[ROB_W-2:0] >= r[ROB_W-2:0];  // redirect wrapped past the entry.
    endfunction

    task automatic model_accept();
        int       b;
        int       s;
        payload_t pl;
        for (int p = 0; p < 2; p++) begin
            if (dis_valid[p]) begin
                b  = int'(dis_lq[p][0]);  // bank by lq parity.
                s  = 0;
                while (s < BANK_SIZE && m_valid[b][s]) begin
                    s++;
                end
                pl = {dis_imm[p], dis_rd[p], dis_rob[p], dis_lq[p]};
                m_valid[b][s] = 1'b1;
                m_rdy[b][s]   = dis_rs1_ready[p];
                m_rs1[b][s]   = dis_rs1[p];
                m_pl[b][s]    = pl;
                if (dis_rs1_ready[p]) begin
                    exp_q[b].push_back({SLOT_W'(s), pl});
                end
            end
        end
    endtask

    task automatic model_pulses(input step_t st);
        for (int b = 0; b < 2; b++) begin
            if (st.suc[b]) begin
                m_valid[b][st.slot[b]] = 1'b0;
            end
            if (st.rep[b]) begin
                exp_q[b].push_back({st.slot[b], m_pl[b][st.slot[b]]});
            end
            for (int i = 0; i < BANK_SIZE; i++) begin
                if ((|st.wk) && m_valid[b][i] && !m_rdy[b][i] &&
                    m_rs1[b][i] == st.wk_preg) begin
                    m_rdy[b][i] = 1'b1;
                    exp_q[b].push_back({SLOT_W'(i), m_pl[b][i]});
                end
                if (st.redir && m_valid[b][i] &&
                    !older_than(m_pl[b][i][LQ_W +: ROB_W], st.redir_rob)) begin
                    m_valid[b][i] = 1'b0;
                    for (int k = exp_q[b].size() - 1; k >= 0; k--) begin
                        if (exp_q[b][k][EXP_W-1:PAYLOAD_W] == SLOT_W'(i)) begin
                            exp_q[b].delete(k);
                        end
                    end
                end
            end
        end
    endtask

    task automatic check_issue(input int b);
        logic [EXP_W-1:0] e;
        checks++;
        if (exp_q[b].size() == 0) begin
            errors++;
            $display("time %0t: bank %0d issued slot %0d with no load expected",
                     $time, b, issue_slot[b]);
        end else begin
            e = exp_q[b].pop_front();
            if (issue_payload[b] !== e[PAYLOAD_W-1:0]) begin
                errors++;
                $display("FAIL time %0t issue_payload_o[%0d] expected %h actual %h",
                         $time, b, e[PAYLOAD_W-1:0], issue_payload[b]);
            end
            if (issue_slot[b] !== e[EXP_W-1:PAYLOAD_W]) begin
                errors++;
                $display("FAIL time %0t issue_slot_o[%0d] expected %0d actual %0d",
                         $time, b, e[EXP_W-1:PAYLOAD_W], issue_slot[b]);
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            for (int b = 0; b < 2; b++) begin
                if (issue_valid[b]) begin
                    check_issue(b);
                end
            end
        end
    end

    // ********************************************************************
    // table rows and their application
    // ********************************************************************
    function automatic step_t blank_step();
        step_t s;
        s      = '{default: 0};
        s.occ0 = -1;
        s.occ1 = -1;
        return s;
    endfunction

    task automatic dispatch_pair(input logic [1:0] dv, input logic [1:0] rdy,
                                 input preg_t rs1a, input preg_t rs1b, input rob_idx_t rob,
                                 input lq_idx_t lq, input logic stall,
                                 input logic [1:0] suc, input int sl);
        step_t s;
        s           = blank_step();
        s.dv        = dv;
        s.rdy       = rdy;
        s.rs1[0]    = rs1a;
        s.rs1[1]    = rs1b;
        s.imm[0]    = imm_t'($urandom);
        s.imm[1]    = imm_t'($urandom);
        s.rob       = rob;
        s.lq        = lq;
        s.exp_stall = stall;
        s.suc       = suc;  // frees room for a stalled group.
        s.slot[0]   = SLOT_W'(sl);
        s.slot[1]   = SLOT_W'(sl);
        steps.push_back(s);
    endtask

    task automatic wake_reg(input preg_t p, input int port);
        step_t s;
        s          = blank_step();
        s.wk[port] = 1'b1;
        s.wk_preg  = p;
        steps.push_back(s);
    endtask

    task automatic complete_slots(input logic [1:0] suc, input logic [1:0] rep,
                                  input int s0, input int s1);
        step_t s;
        s         = blank_step();
        s.suc     = suc;
        s.rep     = rep;
        s.slot[0] = SLOT_W'(s0);
        s.slot[1] = SLOT_W'(s1);
        steps.push_back(s);
    endtask

    task automatic flush_after(input rob_idx_t r);
        step_t s;
        s           = blank_step();
        s.redir     = 1'b1;
        s.redir_rob = r;
        steps.push_back(s);
    endtask

    task automatic wait_idle(input int n, input int o0, input int o1);
        step_t s;
        for (int i = 0; i < n; i++) begin
            s = blank_step();
            if (i == n - 1) begin
                s.occ0 = o0;
                s.occ1 = o1;
            end
            steps.push_back(s);
        end
    endtask

    task automatic check_occ(input int b, input int exp_occ);
        checks++;
        if (occupancy[b] !== (SLOT_W + 1)'(exp_occ)) begin
            errors++;
            $display("FAIL time %0t occupancy_o[%0d] expected %0d actual %0d",
                     $time, b, exp_occ, occupancy[b]);
        end
    endtask

    task automatic apply_step(input step_t st);
        logic held;
        for (int p = 0; p < 2; p++) begin
            dis_rs1[p]       = st.rs1[p];
            dis_rs1_ready[p] = st.rdy[p];
            dis_imm[p]       = st.imm[p];
            dis_rob[p]       = st.rob + rob_idx_t'(p);
            dis_lq[p]        = st.lq + lq_idx_t'(p);
            dis_rd[p]        = {1'b1, dis_lq[p]};
        end
        dis_valid    = st.dv;
        wk_valid     = st.wk;
        wk_preg[0]   = st.wk_preg;
        wk_preg[1]   = st.wk_preg;
        success      = st.suc;
        replay       = st.rep;
        success_slot = st.slot;
        replay_slot  = st.slot;
        redirect     = st.redir;
        redirect_rob = st.redir_rob;
        model_pulses(st);
        @(negedge clk);
        checks++;
        if (dis_stall !== st.exp_stall) begin
            errors++;
            $display("FAIL time %0t dis_stall_o expected %b actual %b",
                     $time, st.exp_stall, dis_stall);
        end
        if (st.occ0 >= 0) begin
            check_occ(0, st.occ0);
        end
        if (st.occ1 >= 0) begin
            check_occ(1, st.occ1);
        end
        held = dis_stall;
        @(posedge clk);
        #10;
        wk_valid = '0;  // pulses last one cycle.
        success  = '0;
        replay   = '0;
        redirect = 1'b0;
        while (held) begin
            @(negedge clk);
            held = dis_stall;
            @(posedge clk);
            #10;
        end
        if (|dis_valid) begin
            model_accept();
        end
        dis_valid = '0;
    endtask

    initial begin
        errors = 0;
        checks = 0;
        cycles = 0;
        limit  = 0;
        clk    = 1'b0;
        rst    = 1'b1;
        dis_valid     = '0;
        dis_rs1       = '0;
        dis_rs1_ready = '0;
        dis_rd        = '0;
        dis_imm       = '0;
        dis_rob       = '0;
        dis_lq        = '0;
        wk_valid      = '0;
        wk_preg       = '0;
        success       = '0;
        success_slot  = '0;
        replay        = '0;
        replay_slot   = '0;
        redirect      = 1'b0;
        redirect_rob  = '0;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < BANK_SIZE; i++) begin
                m_valid[b][i] = 1'b0;
                m_rdy[b][i]   = 1'b0;
            end
        end
        void'($urandom(80513));

        wait_idle(1, 0, 0);
        dispatch_pair(2'b11, 2'b11, 6'd1, 6'd2, 6'd0, 5'd0, 1'b0, 2'b00, 0);
        dispatch_pair(2'b11, 2'b11, 6'd3, 6'd4, 6'd2, 5'd3, 1'b0, 2'b00, 0);  // odd lq on port 0.
        wait_idle(4, 2, 2);
        dispatch_pair(2'b11, 2'b01, 6'd5, 6'd20, 6'd4, 5'd5, 1'b0, 2'b00, 0);
        wait_idle(4, 3, 3);
        wake_reg(6'd20, 0);
        wait_idle(4, 3, 3);
        complete_slots(2'b00, 2'b11, 2, 0);
        wait_idle(4, 3, 3);
        for (int s = 0; s < 3; s++) begin
            complete_slots(2'b11, 2'b00, s, s);
        end
        wait_idle(4, 0, 0);
        for (int i = 0; i < BANK_SIZE; i++) begin
            dispatch_pair(2'b11, 2'b11, 6'(i + 1), 6'(i + 9), 6'(6 + 2 * i), 5'(8 + 2 * i),
                          1'b0, 2'b00, 0);
        end
        wait_idle(6, BANK_SIZE, BANK_SIZE);
        dispatch_pair(2'b11, 2'b11, 6'd1, 6'd2, 6'd22, 5'd24, 1'b1, 2'b11, 3);
        wait_idle(6, BANK_SIZE, BANK_SIZE);
        for (int s = 0; s < BANK_SIZE; s++) begin
            complete_slots(2'b11, 2'b00, s, s);
        end
        wait_idle(4, 0, 0);
        // rob 30..33 straddle the direction bit.
        dispatch_pair(2'b11, 2'b00, 6'd40, 6'd40, 6'd30, 5'd26, 1'b0, 2'b00, 0);
        dispatch_pair(2'b11, 2'b11, 6'd40, 6'd40, 6'd32, 5'd28, 1'b0, 2'b00, 0);
        wait_idle(1, 2, 2);  // the younger pair is selected just before the flush.
        flush_after(6'd32);
        wait_idle(2, 1, 1);
        wake_reg(6'd40, 1);
        wait_idle(4, 1, 1);
        complete_slots(2'b11, 2'b00, 0, 0);
        wait_idle(4, 0, 0);

        limit = steps.size() * 8;
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        for (int b = 0; b < 2; b++) begin
            if (exp_q[b].size() != 0) begin
                errors++;
                $display("bank %0d: %0d expected issues never appeared", b, exp_q[b].size());
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
design/ldq_pkg.sv
design/payload_ram.sv
design/dispatch_router.sv
design/load_issue_bank.sv
design/issue_stage.sv
design/load_issue_top.sv
dv/load_issue_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f build.f \
    --top-module load_issue_tb -o load_issue_sim

out=$(./obj_dir/load_issue_sim)
echo "$out"

# a missing pass line makes grep, and so the script, fail.
echo "$out" | grep -q "TEST RESULT: PASS"
